// File: fetch_stage.f
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/icache.sv
hdl/fetch_queue.sv
hdl/branch_predictor.sv
hdl/fetch_stage.sv
verif/tb_clock_gen.sv
verif/tb_fetch_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= fetch_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_fetch_stage.sv
`timescale 1ns/1ps

module tb_fetch_stage;

    import fetch_pkg::*;

    localparam int              CACHE_LINES = 16;
    localparam int              QUEUE_DEPTH = 4;
    localparam int              BTB_ENTRIES = 8;
    localparam logic [XLEN-1:0] RESET_PC    = 32'h0000_0040;
    localparam int              NUM_OUTPUTS = 300;
    localparam int              MAX_LATENCY = 6;
    // every output may wait for a full refill and a stall, doubled for redirects.
    localparam int              TIMEOUT_CYCLES = NUM_OUTPUTS * (2 * MAX_LATENCY + 1);
    localparam int              OFFS_BITS   = $clog2(LINE_BITS / 8);
    localparam int              IDX_BITS    = $clog2(CACHE_LINES);
    localparam int              BTB_BITS    = $clog2(BTB_ENTRIES);

    logic            clk;
    logic            arst_n;
    logic            stall;
    redirect_t       redirect;
    bp_update_t      bp_update;
    fetch_out_t      fetch_out;
    logic            mem_req;
    logic [XLEN-1:0] mem_addr;
    logic            mem_ready;
    logic            mem_valid;
    line_t           mem_line;

    logic [31:0]     lcg_state;
    logic            mem_busy;
    int              mem_wait;
    logic [XLEN-1:0] trained_pc;
    logic            bp_valid   [BTB_ENTRIES];
    logic [XLEN-1:0] bp_tag     [BTB_ENTRIES];
    logic [XLEN-1:0] bp_target  [BTB_ENTRIES];
    logic            line_valid [CACHE_LINES];
    logic [XLEN-1:0] line_addr  [CACHE_LINES];
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] want_addr;
    logic            want_valid;
    logic            redirect_prev;
    logic            req_prev;
    logic            hold_prev;
    logic            redirect_any;
    fetch_out_t      exp_out;
    fetch_out_t      held_out;
    int              consumed;
    int              cycles;

    tb_clock_gen clock_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    fetch_stage #(
        .CACHE_LINES (CACHE_LINES),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .BTB_ENTRIES (BTB_ENTRIES),
        .RESET_PC    (RESET_PC)
    ) dut_i (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .stall_i     (stall),
        .redirect_i  (redirect),
        .bp_update_i (bp_update),
        .fetch_o     (fetch_out),
        .mem_req_o   (mem_req),
        .mem_addr_o  (mem_addr),
        .mem_ready_i (mem_ready),
        .mem_valid_i (mem_valid),
        .mem_line_i  (mem_line)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // words 7 of every 8 are addi x1, x1, imm; the eighth is a conditional branch.
    function automatic logic [XLEN-1:0] prog_word(input logic [XLEN-1:0] addr);
        if (addr[4:2] == 3'b111) begin
            return {addr[11:5], 5'd2, 5'd1, 3'b001, addr[16:12], OPC_BRANCH};
        end
        return {addr[13:2], 5'd1, 3'b000, 5'd1, 7'b001_0011};
    endfunction

    function automatic line_t build_line(input logic [XLEN-1:0] addr);
        line_t line;
        for (int w = 0; w < LINE_BITS / XLEN; w++) begin
            line[w * XLEN +: XLEN] = prog_word({addr[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}}
                                               + XLEN'(4 * w));
        end
        return line;
    endfunction

    function automatic logic [IDX_BITS-1:0] line_idx(input logic [XLEN-1:0] addr);
        return addr[OFFS_BITS +: IDX_BITS];
    endfunction

    function automatic logic model_taken(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0]     instr;
        logic [BTB_BITS-1:0] idx;
        instr = prog_word(pc);
        idx   = pc[2 +: BTB_BITS];
        return (instr[6:0] == OPC_BRANCH) && bp_valid[idx] && (bp_tag[idx] == pc);
    endfunction

    function automatic logic [XLEN-1:0] expected_next_pc(input redirect_t r,
                                                         input logic [XLEN-1:0] pc);
        return r.mispredict_valid ? r.mispredict_target :
               r.jal_valid        ? r.jal_target :
               r.mret_valid       ? r.mret_target :
               model_taken(pc)    ? bp_target[pc[2 +: BTB_BITS]] : pc + XLEN'(4);
    endfunction

    task automatic apply_update(input bp_update_t up);
        logic [BTB_BITS-1:0] idx;
        idx = up.pc[2 +: BTB_BITS];
        if (up.valid && up.taken) begin
            bp_valid[idx]  = 1'b1;
            bp_tag[idx]    = up.pc;
            bp_target[idx] = up.target;
        end else if (up.valid && bp_valid[idx] && bp_tag[idx] == up.pc) begin
            bp_valid[idx] = 1'b0;
        end
    endtask

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    // fields are shown as valid/pc/instr/predict_taken.
    task automatic check_out(input string name, input fetch_out_t got, input fetch_out_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0b/%h/%h/%0b expected %0b/%h/%h/%0b", $time, name,
                     got.valid, got.pc, got.instr, got.predict_taken,
                     exp.valid, exp.pc, exp.instr, exp.predict_taken);
            abort_run();
        end
    endtask

    task automatic check_mem_addr(input string name, input logic [XLEN-1:0] got,
                                  input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0b expected %0b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_redirect();
        redirect_t       r;
        bp_update_t      up;
        logic [XLEN-1:0] chosen;
        r  = '0;
        up = '0;
        lcg_state = lcg_next(lcg_state);
        r.mispredict_valid  = lcg_state[31];
        r.jal_valid         = lcg_state[30];
        r.mret_valid        = lcg_state[29] || !(lcg_state[31] || lcg_state[30]);
        r.mispredict_target = XLEN'({lcg_state[27:18], 2'b00});
        r.jal_target        = XLEN'({lcg_state[17:8], 2'b00});
        lcg_state = lcg_next(lcg_state);
        r.mret_target = XLEN'({lcg_state[31:22], 2'b00});
        chosen = expected_next_pc(r, '0);
        if (lcg_state[21]) begin
            up = '{valid: 1'b1, taken: 1'b1, pc: chosen | XLEN'(28),
                   target: XLEN'({lcg_state[19:10], 2'b00})}; // the branch ahead of the target.
            trained_pc = up.pc;
        end else if (lcg_state[20]) begin
            up = '{valid: 1'b1, taken: 1'b0, pc: trained_pc, target: '0};
        end
        redirect  <= r;
        bp_update <= up;
    endtask

    initial begin
        lcg_state  = 32'h8c07_5872;
        trained_pc = RESET_PC | XLEN'(28);
        mem_busy   = 1'b0;
        mem_wait   = 0;
        stall      = 1'b0;
        redirect   = '0;
        bp_update  = '0;
        mem_ready  = 1'b0;
        mem_valid  = 1'b0;
        mem_line   = '0;
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            lcg_state = lcg_next(lcg_state);
            mem_valid <= 1'b0;
            mem_ready <= (lcg_state[31:30] != 2'b00);
            if (mem_busy) begin
                if (mem_wait == 0) begin
                    mem_valid <= 1'b1;
                    mem_line  <= build_line(mem_addr);
                    mem_busy = 1'b0;
                end else begin
                    mem_wait = mem_wait - 1;
                end
            end else if (mem_req && !mem_valid) begin
                mem_busy = 1'b1;
                mem_wait = lcg_state[29:27] % MAX_LATENCY;
            end
            stall     <= (consumed >= 40) && (lcg_state[26:25] == 2'b00);
            redirect  <= '0;
            bp_update <= '0;
            if (consumed >= 100 && lcg_state[24:21] == 4'd0) begin
                drive_redirect();
            end
        end
    end

    assign redirect_any = redirect.mispredict_valid || redirect.jal_valid
                        || redirect.mret_valid;

    always @(negedge clk) begin
        if (!arst_n) begin
            check_flag("fetch_o.valid", fetch_out.valid, 1'b0);
            check_flag("mem_req_o", mem_req, 1'b0);
            exp_pc        = RESET_PC;
            want_addr     = {RESET_PC[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}};
            want_valid    = 1'b1;
            redirect_prev = 1'b0;
            req_prev      = 1'b0;
            hold_prev     = 1'b0;
            cycles        = 0;
            consumed      = 0;
            line_valid    = '{default: 1'b0};
            bp_valid      = '{default: 1'b0};
        end else begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout after %0d cycles with %0d of %0d outputs checked",
                         cycles, consumed, NUM_OUTPUTS);
                abort_run();
            end
            if (redirect_prev) begin
                check_flag("fetch_o.valid after redirect", fetch_out.valid, 1'b0);
            end
            if (hold_prev) begin
                check_out("fetch_o during stall", fetch_out, held_out);
            end
            if (mem_req && !req_prev) begin
                check_mem_addr("mem_addr_o offset", mem_addr & XLEN'(LINE_BITS / 8 - 1), '0);
                if (line_valid[line_idx(mem_addr)]
                    && line_addr[line_idx(mem_addr)] == mem_addr) begin
                    $display("line %h requested again while it is still cached", mem_addr);
                    abort_run();
                end
                if (want_valid && !redirect_prev) begin
                    check_mem_addr("mem_addr_o", mem_addr, want_addr);
                end
            end
            if (mem_req && mem_valid) begin
                line_valid[line_idx(mem_addr)] = 1'b1;
                line_addr[line_idx(mem_addr)]  = mem_addr;
                want_valid = want_valid && (want_addr != mem_addr);
            end
            if (redirect_any) begin
                exp_pc     = expected_next_pc(redirect, exp_pc);
                want_addr  = {exp_pc[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}};
                want_valid = !(line_valid[line_idx(exp_pc)]
                               && line_addr[line_idx(exp_pc)] == want_addr);
            end else if (fetch_out.valid && !stall) begin
                exp_out = '{valid: 1'b1, pc: exp_pc, instr: prog_word(exp_pc),
                            predict_taken: model_taken(exp_pc)};
                check_out("fetch_o", fetch_out, exp_out);
                exp_pc = expected_next_pc(redirect, exp_pc);
                consumed++;
            end
            apply_update(bp_update); // the table changes at the end of the cycle.
            redirect_prev = redirect_any;
            req_prev      = mem_req;
            hold_prev     = stall && !redirect_any;
            held_out      = fetch_out;
            if (consumed == NUM_OUTPUTS) begin
                $display("Verification passed");
                $finish;
            end
        end
    end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 10.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1; // release on an edge, the DUT sees reset for the whole edge.
    end

    always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int                         CACHE_LINES = 16,
    parameter int                         QUEUE_DEPTH = 4,
    parameter int                         BTB_ENTRIES = 8,
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = '0
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        stall_i,
    input  fetch_pkg::redirect_t        redirect_i,
    input  fetch_pkg::bp_update_t       bp_update_i,
    output fetch_pkg::fetch_out_t       fetch_o,
    output logic                        mem_req_o,
    output logic [fetch_pkg::XLEN-1:0]  mem_addr_o,
    input  logic                        mem_ready_i,
    input  logic                        mem_valid_i,
    input  fetch_pkg::line_t            mem_line_i
);

    import fetch_pkg::*;

    logic [XLEN-1:0] fetch_pc;
    logic            cache_hit;
    logic [XLEN-1:0] cache_instr;
    logic            redirect_any;
    logic            predict_take;
    logic            bp_taken;
    logic [XLEN-1:0] bp_target;
    logic            q_push;
    logic            q_pop;
    logic            q_flush;
    logic            q_empty;
    logic            q_full;
    fq_entry_t       q_head;
    fq_entry_t       q_push_entry;
    fetch_out_t      out_q;

    assign redirect_any = redirect_i.mispredict_valid | redirect_i.jal_valid
                        | redirect_i.mret_valid;

    assign q_pop        = !stall_i && !q_empty;
    assign predict_take = q_pop && bp_taken; // the taken branch leaves the queue now.
    assign q_flush      = redirect_any || predict_take;
    assign q_push       = cache_hit && !q_full && !q_flush;
    assign q_push_entry = '{pc: fetch_pc, instr: cache_instr};

    pc_gen #(
        .RESET_PC(RESET_PC)
    ) pc_gen_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .hold_i           (!q_push),
        .redirect_i       (redirect_i),
        .predict_take_i   (predict_take),
        .predict_target_i (bp_target),
        .pc_o             (fetch_pc)
    );

    icache #(
        .CACHE_LINES(CACHE_LINES)
    ) icache_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pc_i        (fetch_pc),
        .hit_o       (cache_hit),
        .instr_o     (cache_instr),
        .mem_req_o   (mem_req_o),
        .mem_addr_o  (mem_addr_o),
        .mem_ready_i (mem_ready_i),
        .mem_valid_i (mem_valid_i),
        .mem_line_i  (mem_line_i)
    );

    fetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) fetch_queue_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .push_i       (q_push),
        .push_entry_i (q_push_entry),
        .pop_i        (q_pop),
        .flush_i      (q_flush),
        .head_o       (q_head),
        .empty_o      (q_empty),
        .full_o       (q_full)
    );

    branch_predictor #(
        .BTB_ENTRIES(BTB_ENTRIES)
    ) branch_predictor_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .head_i           (q_head),
        .update_i         (bp_update_i),
        .predict_taken_o  (bp_taken),
        .predict_target_o (bp_target)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '{valid: 1'b0, pc: RESET_PC, instr: NOP_INSTR, predict_taken: 1'b0};
        end else if (redirect_any) begin
            out_q.valid <= 1'b0; // wrong path, drop it even when stalled.
        end else if (!stall_i) begin
            if (!q_empty) begin
                out_q <= '{valid: 1'b1, pc: q_head.pc, instr: q_head.instr,
                           predict_taken: bp_taken};
            end else begin
                out_q.valid <= 1'b0;
                out_q.instr <= NOP_INSTR;
            end
        end
    end

    assign fetch_o = out_q;

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BTB_ENTRIES = 8
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  fetch_pkg::fq_entry_t        head_i,
    input  fetch_pkg::bp_update_t       update_i,
    output logic                        predict_taken_o,
    output logic [fetch_pkg::XLEN-1:0]  predict_target_o
);

    import fetch_pkg::*;

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);

    logic [BTB_ENTRIES-1:0] valid_q;
    logic [XLEN-1:0]        tag_q    [BTB_ENTRIES];
    logic [XLEN-1:0]        target_q [BTB_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] up_idx;
    logic                is_branch;
    logic                up_tag_match;

    assign rd_idx = head_i.pc[2 +: IDX_BITS];
    assign up_idx = update_i.pc[2 +: IDX_BITS];

    // only conditional branches are predicted, jumps resolve later.
    assign is_branch = (head_i.instr[6:0] == OPC_BRANCH);

    assign predict_taken_o  = is_branch && valid_q[rd_idx] && (tag_q[rd_idx] == head_i.pc);
    assign predict_target_o = target_q[rd_idx];

    assign up_tag_match = valid_q[up_idx] && (tag_q[up_idx] == update_i.pc);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (update_i.valid) begin
            if (update_i.taken) begin
                valid_q[up_idx] <= 1'b1;
            end else if (up_tag_match) begin
                valid_q[up_idx] <= 1'b0; // not taken, forget this branch.
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (update_i.valid && update_i.taken) begin
            tag_q[up_idx]    <= update_i.pc;
            target_q[up_idx] <= update_i.target;
        end
    end

endmodule

// File: hdl/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  push_i,
    input  fetch_pkg::fq_entry_t  push_entry_i,
    input  logic                  pop_i,
    input  logic                  flush_i,
    output fetch_pkg::fq_entry_t  head_o,
    output logic                  empty_o,
    output logic                  full_o
);

    import fetch_pkg::*;

    localparam int PTR_BITS = $clog2(QUEUE_DEPTH);

    fq_entry_t           mem_q [QUEUE_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS:0]   count_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0; // change of flow drops every entry.
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i && !flush_i) begin
            mem_q[wr_ptr_q] <= push_entry_i;
        end
    end

    assign head_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == (PTR_BITS + 1)'(QUEUE_DEPTH));

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push_i |-> !full_o)
        else $error("push into a full fetch queue");

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop_i |-> !empty_o)
        else $error("pop from an empty fetch queue");

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int CACHE_LINES = 16
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [fetch_pkg::XLEN-1:0]  pc_i,
    output logic                        hit_o,
    output logic [fetch_pkg::XLEN-1:0]  instr_o,
    output logic                        mem_req_o,
    output logic [fetch_pkg::XLEN-1:0]  mem_addr_o,
    input  logic                        mem_ready_i,
    input  logic                        mem_valid_i,
    input  fetch_pkg::line_t            mem_line_i
);

    import fetch_pkg::*;

    localparam int OFFS_BITS = $clog2(LINE_BITS / 8);
    localparam int IDX_BITS  = $clog2(CACHE_LINES);
    localparam int TAG_BITS  = XLEN - OFFS_BITS - IDX_BITS;
    localparam int WORD_BITS = $clog2(LINE_BITS / XLEN);

    typedef enum logic {
        S_IDLE,
        S_WAIT
    } refill_state_t;

    refill_state_t state_q;

    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]    tag_q  [CACHE_LINES];
    line_t                  line_q [CACHE_LINES];

    logic [XLEN-1:0]      addr_q;
    logic [IDX_BITS-1:0]  rd_idx;
    logic [TAG_BITS-1:0]  rd_tag;
    logic [IDX_BITS-1:0]  wr_idx;
    logic [WORD_BITS-1:0] word_sel;
    line_t                rd_line;

    assign rd_idx   = pc_i[OFFS_BITS +: IDX_BITS];
    assign rd_tag   = pc_i[XLEN-1 -: TAG_BITS];
    assign wr_idx   = addr_q[OFFS_BITS +: IDX_BITS];
    assign word_sel = pc_i[2 +: WORD_BITS];

    // combinational read, the word is ready in the cycle the pc is shown.
    assign rd_line = line_q[rd_idx];
    assign hit_o   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign instr_o = rd_line[word_sel * XLEN +: XLEN];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (!hit_o && mem_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem_valid_i) begin
                        state_q         <= S_IDLE;
                        valid_q[wr_idx] <= 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && !hit_o && mem_ready_i) begin
            addr_q <= {pc_i[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}}; // line aligned.
        end
        if (state_q == S_WAIT && mem_valid_i) begin
            tag_q[wr_idx]  <= addr_q[XLEN-1 -: TAG_BITS];
            line_q[wr_idx] <= mem_line_i;
        end
    end

    assign mem_req_o  = (state_q == S_WAIT);
    assign mem_addr_o = addr_q;

    // the memory side relies on the address holding while it works on the line.
    a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_req_o && !mem_valid_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("memory request dropped or address moved before the line returned");

endmodule

// File: hdl/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        hold_i,
    input  fetch_pkg::redirect_t        redirect_i,
    input  logic                        predict_take_i,
    input  logic [fetch_pkg::XLEN-1:0]  predict_target_i,
    output logic [fetch_pkg::XLEN-1:0]  pc_o
);

    import fetch_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    always_comb begin
        if (redirect_i.mispredict_valid) begin
            pc_next = redirect_i.mispredict_target;
        end else if (redirect_i.jal_valid) begin
            pc_next = redirect_i.jal_target;
        end else if (redirect_i.mret_valid) begin
            pc_next = redirect_i.mret_target;
        end else if (predict_take_i) begin
            pc_next = predict_target_i; // taken branch left the queue head.
        end else if (hold_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + XLEN'(4);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // targets come from decode and the predictor, so misalignment would enter from outside.
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pc_o[1:0] == 2'b00)
        else $error("fetch pc is not word aligned");

endmodule

// File: hdl/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN      = 32;
    localparam int LINE_BITS = 128;

    localparam logic [XLEN-1:0] NOP_INSTR  = 32'h0000_0013; // addi x0, x0, 0.
    localparam logic [6:0]      OPC_BRANCH = 7'b110_0011;

    typedef logic [LINE_BITS-1:0] line_t;

    // redirects from the later stages, highest priority first.
    typedef struct packed {
        logic            mispredict_valid;
        logic [XLEN-1:0] mispredict_target;
        logic            jal_valid;
        logic [XLEN-1:0] jal_target;
        logic            mret_valid;
        logic [XLEN-1:0] mret_target;
    } redirect_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
    } bp_update_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fq_entry_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            predict_taken;
    } fetch_out_t;

endpackage
